// ==== files.f ====
logic/cce_cfg_pkg.sv
logic/cce_msg_pkg.sv
logic/cce_msg_buffer.sv
logic/cce_directory.sv
logic/cce_ctrl.sv
logic/cce_lce_cmd_out.sv
logic/cce_top.sv
tb/cce_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CCE testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cce_tb -Mdir obj_dir -o cce_sim -f files.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/cce_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

// ==== tb/cce_tb.sv ====
/*
 * CCE testbench
 * Drives LCE requests, models memory with a random response delay and
 * checks every LCE and memory command against a directory model
 */

`timescale 1ns/10ps
`default_nettype none

module cce_tb;

  localparam int NUM_LCE = 4;
  localparam int TIMEOUT = 400;
  localparam int NUM_RANDOM = 200;

  typedef logic [cce_cfg_pkg::LINE_ADDR_W-1:0] addr_t;
  typedef logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce_id_t;
  typedef logic [cce_cfg_pkg::DATA_W-1:0]      data_t;

  logic    clk_i;
  logic    rst_n_i;
  logic    lce_req_v_i;
  lce_id_t lce_req_lce_i;
  addr_t   lce_req_addr_i;
  logic    lce_req_write_i;
  logic    lce_req_ready_o;
  logic    mem_cmd_v_o;
  addr_t   mem_cmd_addr_o;
  logic    mem_cmd_ready_i;
  logic    mem_resp_v_i;
  addr_t   mem_resp_addr_i;
  data_t   mem_resp_data_i;
  logic    mem_resp_ready_o;
  logic    lce_cmd_v_o;
  lce_id_t lce_cmd_lce_o;
  addr_t   lce_cmd_addr_o;
  data_t   lce_cmd_data_o;
  logic    lce_cmd_ready_i;
  cce_msg_pkg::lce_cmd_type_e lce_cmd_type_o;
  cce_msg_pkg::coh_state_e    lce_cmd_state_o;

  integer seed     = 32'h3fad_b0a1;
  integer mem_seed = 32'h3fad_b0a1 ^ 32'h0000_5a5a;
  integer bp_seed  = 32'h3fad_b0a1 ^ 32'h0000_a5a5;
  logic   bp_en;
  int     inv_count;

  // Directory model
  logic [NUM_LCE-1:0] ref_mask [cce_cfg_pkg::DIR_LINES];
  logic               ref_excl [cce_cfg_pkg::DIR_LINES];

  // Expected LCE commands and memory addresses in issue order
  cce_msg_pkg::lce_cmd_type_e q_type[$];
  lce_id_t                    q_lce[$];
  addr_t                      q_addr[$];
  cce_msg_pkg::coh_state_e    q_state[$];
  data_t                      q_data[$];
  addr_t                      mem_q[$];

  cce_top #(
    .NUM_LCE(NUM_LCE)
  ) DUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .lce_req_v_i     (lce_req_v_i),
    .lce_req_lce_i   (lce_req_lce_i),
    .lce_req_addr_i  (lce_req_addr_i),
    .lce_req_write_i (lce_req_write_i),
    .lce_req_ready_o (lce_req_ready_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_addr_i (mem_resp_addr_i),
    .mem_resp_data_i (mem_resp_data_i),
    .mem_resp_ready_o(mem_resp_ready_o),
    .lce_cmd_v_o     (lce_cmd_v_o),
    .lce_cmd_type_o  (lce_cmd_type_o),
    .lce_cmd_lce_o   (lce_cmd_lce_o),
    .lce_cmd_addr_o  (lce_cmd_addr_o),
    .lce_cmd_state_o (lce_cmd_state_o),
    .lce_cmd_data_o  (lce_cmd_data_o),
    .lce_cmd_ready_i (lce_cmd_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s at t=%0t", why, $time);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_type(input string name, input cce_msg_pkg::lce_cmd_type_e got,
                            input cce_msg_pkg::lce_cmd_type_e exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      fail_run("LCE command type mismatch");
    end
  endtask

  task automatic check_state(input string name, input cce_msg_pkg::coh_state_e got,
                             input cce_msg_pkg::coh_state_e exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      fail_run("Coherence state mismatch");
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      fail_run("Command data mismatch");
    end
  endtask

  task automatic check_id(input string name, input lce_id_t got, input lce_id_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
      fail_run("LCE id mismatch");
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      fail_run("Line address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      fail_run("Control signal mismatch");
    end
  endtask

  // Memory contents as a fixed mix of every address bit
  function automatic data_t line_data(input addr_t addr);
    data_t a;
    a = {26'd0, addr};
    return (a * 32'h9e37_79b1) ^ {addr, addr, addr, addr, addr, 2'b10};
  endfunction

  // Applies the coherence rule to the directory model entry
  function automatic void predict(input lce_id_t lce, input addr_t addr, input logic wr,
                                  output logic [NUM_LCE-1:0] inv,
                                  output cce_msg_pkg::coh_state_e state,
                                  output data_t data);
    logic [NUM_LCE-1:0] req_bit;
    logic [NUM_LCE-1:0] others;
    req_bit = {{(NUM_LCE-1){1'b0}}, 1'b1} << lce;
    others  = ref_mask[addr] & ~req_bit;
    if (wr) begin
      inv   = others;
      state = cce_msg_pkg::e_coh_exclusive;
      ref_mask[addr] = req_bit;
      ref_excl[addr] = 1'b1;
    end else begin
      inv   = ref_excl[addr] ? others : '0;
      state = cce_msg_pkg::e_coh_shared;
      ref_mask[addr] = (ref_mask[addr] & ~inv) | req_bit;
      ref_excl[addr] = 1'b0;
    end
    data = line_data(addr);
  endfunction

  task automatic wait_req_ready();
    int n;
    n = 0;
    while (!lce_req_ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) fail_run("Request port never became ready");
    end
  endtask

  // Waits until every expected command has gone out
  task automatic wait_drain();
    int n;
    n = 0;
    while (q_type.size() != 0 || mem_q.size() != 0 || lce_cmd_v_o) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) fail_run("Expected commands still outstanding");
    end
  endtask

  // Called on a falling edge
  task automatic send_req(input lce_id_t lce, input addr_t addr, input logic wr);
    logic [NUM_LCE-1:0]      inv;
    cce_msg_pkg::coh_state_e st;
    data_t                   d;
    wait_req_ready();
    predict(lce, addr, wr, inv, st, d);
    for (int i = 0; i < NUM_LCE; i++) begin
      if (inv[i]) begin
        q_type.push_back(cce_msg_pkg::e_cmd_inv);
        q_lce.push_back(cce_cfg_pkg::LCE_ID_W'(i));
        q_addr.push_back(addr);
        q_state.push_back(cce_msg_pkg::e_coh_invalid);
        q_data.push_back('0);
      end
    end
    q_type.push_back(cce_msg_pkg::e_cmd_fill);
    q_lce.push_back(lce);
    q_addr.push_back(addr);
    q_state.push_back(st);
    q_data.push_back(d);
    mem_q.push_back(addr);
    lce_req_v_i     = 1'b1;
    lce_req_lce_i   = lce;
    lce_req_addr_i  = addr;
    lce_req_write_i = wr;
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  // Back-pressure and compare on the LCE command port
  initial begin
    cce_msg_pkg::lce_cmd_type_e et;
    cce_msg_pkg::coh_state_e    es;
    lce_id_t                    el;
    addr_t                      ea;
    data_t                      ed;
    lce_cmd_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (rst_n_i) begin
        lce_cmd_ready_i = bp_en ? (($random(bp_seed) & 3) != 0) : 1'b1;
        if (lce_cmd_v_o && lce_cmd_ready_i) begin
          if (q_type.size() == 0) fail_run("LCE command with nothing expected");
          et = q_type.pop_front();
          el = q_lce.pop_front();
          ea = q_addr.pop_front();
          es = q_state.pop_front();
          ed = q_data.pop_front();
          check_type("lce_cmd_type_o", lce_cmd_type_o, et);
          check_id("lce_cmd_lce_o", lce_cmd_lce_o, el);
          check_addr("lce_cmd_addr_o", lce_cmd_addr_o, ea);
          check_state("lce_cmd_state_o", lce_cmd_state_o, es);
          check_data("lce_cmd_data_o", lce_cmd_data_o, ed);
          if (et == cce_msg_pkg::e_cmd_inv) begin
            inv_count++;
          end
        end
      end
    end
  end

  // Memory model answering each line read after 0 to 3 cycles
  initial begin
    int    delay;
    int    n;
    addr_t ea;
    mem_cmd_ready_i = 1'b1;
    mem_resp_v_i    = 1'b0;
    mem_resp_addr_i = '0;
    mem_resp_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && mem_cmd_v_o && mem_cmd_ready_i) begin
        if (mem_q.size() == 0) fail_run("Memory command with nothing expected");
        ea = mem_q.pop_front();
        check_addr("mem_cmd_addr_o", mem_cmd_addr_o, ea);
        delay = $random(mem_seed) & 3;
        @(negedge clk_i);
        repeat (delay) @(negedge clk_i);
        mem_resp_v_i    = 1'b1;
        mem_resp_addr_i = ea;
        mem_resp_data_i = line_data(ea);
        n = 0;
        while (!mem_resp_ready_o) begin
          @(negedge clk_i);
          n++;
          if (n > TIMEOUT) fail_run("Memory response never accepted");
        end
        @(negedge clk_i);
        mem_resp_v_i = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] r;
    rst_n_i         = 1'b0;
    lce_req_v_i     = 1'b0;
    lce_req_lce_i   = '0;
    lce_req_addr_i  = '0;
    lce_req_write_i = 1'b0;
    bp_en           = 1'b0;
    inv_count       = 0;
    for (int i = 0; i < cce_cfg_pkg::DIR_LINES; i++) begin
      ref_mask[i] = '0;
      ref_excl[i] = 1'b0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Quiet outputs after reset
    repeat (4) begin
      @(negedge clk_i);
      check_bit("lce_cmd_v_o", lce_cmd_v_o, 1'b0);
      check_bit("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
      check_bit("lce_req_ready_o", lce_req_ready_o, 1'b1);
    end

    // Read miss on an untouched line
    send_req(3'd0, 6'd5, 1'b0);
    wait_drain();
    if (inv_count != 0) fail_run("Read of an untouched line sent an invalidation");

    // Three sharers, then a write from one of them
    send_req(3'd0, 6'd9, 1'b0);
    send_req(3'd1, 6'd9, 1'b0);
    send_req(3'd2, 6'd9, 1'b0);
    wait_drain();
    send_req(3'd1, 6'd9, 1'b1);
    wait_drain();
    if (inv_count != 2) fail_run("Write to a shared line did not invalidate two sharers");

    // Read of a line held exclusive elsewhere
    send_req(3'd3, 6'd9, 1'b0);
    wait_drain();
    if (inv_count != 3) fail_run("Read of an exclusive line did not invalidate the owner");

    // Random traffic under LCE command back-pressure
    bp_en = 1'b1;
    for (int k = 0; k < NUM_RANDOM; k++) begin
      r = $random(seed);
      send_req({1'b0, r[1:0]}, r[2] ? {3'b000, r[5:3]} : r[10:5], r[12]);
      repeat (r[15:14]) @(negedge clk_i);
    end
    wait_drain();

    // Engine stays silent once every request is served
    repeat (8) begin
      @(negedge clk_i);
      check_bit("lce_cmd_v_o", lce_cmd_v_o, 1'b0);
      check_bit("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
      check_bit("lce_req_ready_o", lce_req_ready_o, 1'b1);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/cce_top.sv ====
/*
 * CCE top level
 * Inbound buffers, controller, directory and LCE command sequencer
 */

`timescale 1ns/10ps
`default_nettype none

module cce_top #(
  parameter int NUM_LCE = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // LCE request
  input  logic                                lce_req_v_i,
  input  logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce_req_lce_i,
  input  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] lce_req_addr_i,
  input  logic                                lce_req_write_i,
  output logic                                lce_req_ready_o,

  // Memory command, always a line read
  output logic                                mem_cmd_v_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] mem_cmd_addr_o,
  input  logic                                mem_cmd_ready_i,

  // Memory response
  input  logic                                mem_resp_v_i,
  input  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] mem_resp_addr_i,
  input  logic [cce_cfg_pkg::DATA_W-1:0]      mem_resp_data_i,
  output logic                                mem_resp_ready_o,

  // LCE command
  output logic                                lce_cmd_v_o,
  output cce_msg_pkg::lce_cmd_type_e          lce_cmd_type_o,
  output logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce_cmd_lce_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] lce_cmd_addr_o,
  output cce_msg_pkg::coh_state_e             lce_cmd_state_o,
  output logic [cce_cfg_pkg::DATA_W-1:0]      lce_cmd_data_o,
  input  logic                                lce_cmd_ready_i
);

  cce_msg_pkg::lce_req_s  lce_req_li, lce_req_lo;
  cce_msg_pkg::mem_resp_s mem_resp_li, mem_resp_lo;
  logic                   lce_req_v_lo, lce_req_yumi_li;
  logic                   mem_resp_v_lo, mem_resp_yumi_li;

  logic                                dir_r_v, dir_w_v, dir_w_excl, dir_r_excl;
  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] dir_r_addr, dir_w_addr;
  logic [NUM_LCE-1:0]                  dir_r_mask, dir_w_mask;

  logic                                out_start, out_fill, out_done;
  logic [NUM_LCE-1:0]                  out_inv_mask;
  logic [cce_cfg_pkg::LCE_ID_W-1:0]    out_lce;
  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] out_addr;
  cce_msg_pkg::coh_state_e             out_state;
  logic [cce_cfg_pkg::DATA_W-1:0]      out_data;

  // Pack the loose inbound fields
  assign lce_req_li.lce   = lce_req_lce_i;
  assign lce_req_li.addr  = lce_req_addr_i;
  assign lce_req_li.write = lce_req_write_i;
  assign mem_resp_li.addr = mem_resp_addr_i;
  assign mem_resp_li.data = mem_resp_data_i;

  cce_msg_buffer #(
    .msg_t(cce_msg_pkg::lce_req_s)
  ) u_lce_req_buf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (lce_req_v_i),
    .data_i (lce_req_li),
    .ready_o(lce_req_ready_o),
    .v_o    (lce_req_v_lo),
    .data_o (lce_req_lo),
    .yumi_i (lce_req_yumi_li)
  );

  cce_msg_buffer #(
    .msg_t(cce_msg_pkg::mem_resp_s)
  ) u_mem_resp_buf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (mem_resp_v_i),
    .data_i (mem_resp_li),
    .ready_o(mem_resp_ready_o),
    .v_o    (mem_resp_v_lo),
    .data_o (mem_resp_lo),
    .yumi_i (mem_resp_yumi_li)
  );

  cce_ctrl #(
    .NUM_LCE(NUM_LCE)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_v_i        (lce_req_v_lo),
    .req_i          (lce_req_lo),
    .resp_v_i       (mem_resp_v_lo),
    .resp_i         (mem_resp_lo),
    .req_yumi_o     (lce_req_yumi_li),
    .resp_yumi_o    (mem_resp_yumi_li),
    .dir_r_v_o      (dir_r_v),
    .dir_r_addr_o   (dir_r_addr),
    .dir_w_v_o      (dir_w_v),
    .dir_w_addr_o   (dir_w_addr),
    .dir_w_mask_o   (dir_w_mask),
    .dir_w_excl_o   (dir_w_excl),
    .dir_r_mask_i   (dir_r_mask),
    .dir_r_excl_i   (dir_r_excl),
    .mem_cmd_v_o    (mem_cmd_v_o),
    .mem_cmd_addr_o (mem_cmd_addr_o),
    .mem_cmd_ready_i(mem_cmd_ready_i),
    .out_start_o    (out_start),
    .out_inv_mask_o (out_inv_mask),
    .out_lce_o      (out_lce),
    .out_addr_o     (out_addr),
    .out_state_o    (out_state),
    .out_data_o     (out_data),
    .out_fill_o     (out_fill),
    .out_done_i     (out_done)
  );

  cce_directory #(
    .NUM_LCE(NUM_LCE)
  ) u_directory (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .r_v_i   (dir_r_v),
    .r_addr_i(dir_r_addr),
    .r_mask_o(dir_r_mask),
    .r_excl_o(dir_r_excl),
    .w_v_i   (dir_w_v),
    .w_addr_i(dir_w_addr),
    .w_mask_i(dir_w_mask),
    .w_excl_i(dir_w_excl)
  );

  cce_lce_cmd_out #(
    .NUM_LCE(NUM_LCE)
  ) u_lce_cmd_out (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .start_i        (out_start),
    .inv_mask_i     (out_inv_mask),
    .lce_i          (out_lce),
    .addr_i         (out_addr),
    .state_i        (out_state),
    .data_i         (out_data),
    .fill_i         (out_fill),
    .done_o         (out_done),
    .lce_cmd_v_o    (lce_cmd_v_o),
    .lce_cmd_type_o (lce_cmd_type_o),
    .lce_cmd_lce_o  (lce_cmd_lce_o),
    .lce_cmd_addr_o (lce_cmd_addr_o),
    .lce_cmd_state_o(lce_cmd_state_o),
    .lce_cmd_data_o (lce_cmd_data_o),
    .lce_cmd_ready_i(lce_cmd_ready_i)
  );

endmodule

`default_nettype wire

// ==== logic/cce_lce_cmd_out.sv ====
/*
 * CCE LCE command sequencer
 * Walks an invalidation mask from the lowest id upwards, one command
 * per transfer, or sends a single fill to the requester
 */

`timescale 1ns/10ps
`default_nettype none

module cce_lce_cmd_out #(
  parameter int NUM_LCE = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // From the controller
  input  logic                                start_i,
  input  logic [NUM_LCE-1:0]                  inv_mask_i,
  input  logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce_i,
  input  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] addr_i,
  input  cce_msg_pkg::coh_state_e             state_i,
  input  logic [cce_cfg_pkg::DATA_W-1:0]      data_i,
  input  logic                                fill_i,
  output logic                                done_o,

  // LCE command port
  output logic                                lce_cmd_v_o,
  output cce_msg_pkg::lce_cmd_type_e          lce_cmd_type_o,
  output logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce_cmd_lce_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] lce_cmd_addr_o,
  output cce_msg_pkg::coh_state_e             lce_cmd_state_o,
  output logic [cce_cfg_pkg::DATA_W-1:0]      lce_cmd_data_o,
  input  logic                                lce_cmd_ready_i
);

  logic                                busy_r;
  logic                                done_r;
  logic                                fill_r;
  logic [NUM_LCE-1:0]                  mask_r;
  logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce_r;
  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] addr_r;
  cce_msg_pkg::coh_state_e             state_r;
  logic [cce_cfg_pkg::DATA_W-1:0]      data_r;

  logic [cce_cfg_pkg::LCE_ID_W-1:0] low_id;
  logic [NUM_LCE-1:0]               mask_next;
  logic                             xfer;

  // Lowest set bit of the working mask
  always_comb begin
    low_id = '0;
    for (int i = NUM_LCE - 1; i >= 0; i--) begin
      if (mask_r[i]) begin
        low_id = cce_cfg_pkg::LCE_ID_W'(i);
      end
    end
  end

  assign mask_next = mask_r & (mask_r - 1'b1);
  assign xfer      = lce_cmd_v_o && lce_cmd_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
      fill_r <= 1'b0;
      mask_r <= '0;
    end else begin
      done_r <= 1'b0;
      if (start_i) begin
        busy_r <= 1'b1;
        fill_r <= fill_i;
        mask_r <= inv_mask_i;
      end else if (busy_r) begin
        if (fill_r) begin
          if (xfer) begin
            busy_r <= 1'b0;
            done_r <= 1'b1;
          end
        end else if (mask_r == '0) begin
          // Nothing to invalidate
          busy_r <= 1'b0;
          done_r <= 1'b1;
        end else if (xfer) begin
          mask_r <= mask_next;
          if (mask_next == '0) begin
            busy_r <= 1'b0;
            done_r <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      lce_r   <= lce_i;
      addr_r  <= addr_i;
      state_r <= state_i;
      data_r  <= data_i;
    end
  end

  assign done_o = done_r;

  assign lce_cmd_v_o    = busy_r && (fill_r || (mask_r != '0));
  assign lce_cmd_type_o = fill_r ? cce_msg_pkg::e_cmd_fill : cce_msg_pkg::e_cmd_inv;
  assign lce_cmd_lce_o  = fill_r ? lce_r : low_id;
  assign lce_cmd_addr_o = addr_r;

  // Invalidations carry no state and no data
  assign lce_cmd_state_o = fill_r ? state_r : cce_msg_pkg::e_coh_invalid;
  assign lce_cmd_data_o  = fill_r ? data_r : '0;

endmodule

`default_nettype wire

// ==== logic/cce_ctrl.sv ====
/*
 * CCE controller
 * Serves one LCE request at a time: directory lookup, invalidations,
 * memory read, fill to the requester and directory update
 */

`timescale 1ns/10ps
`default_nettype none

module cce_ctrl #(
  parameter int NUM_LCE = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // Inbound buffers
  input  logic                   req_v_i,
  input  cce_msg_pkg::lce_req_s  req_i,
  input  logic                   resp_v_i,
  input  cce_msg_pkg::mem_resp_s resp_i,
  output logic                   req_yumi_o,
  output logic                   resp_yumi_o,

  // Directory
  output logic                                dir_r_v_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] dir_r_addr_o,
  output logic                                dir_w_v_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] dir_w_addr_o,
  output logic [NUM_LCE-1:0]                  dir_w_mask_o,
  output logic                                dir_w_excl_o,
  input  logic [NUM_LCE-1:0]                  dir_r_mask_i,
  input  logic                                dir_r_excl_i,

  // Memory command
  output logic                                mem_cmd_v_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] mem_cmd_addr_o,
  input  logic                                mem_cmd_ready_i,

  // LCE command sequencer
  output logic                                out_start_o,
  output logic [NUM_LCE-1:0]                  out_inv_mask_o,
  output logic [cce_cfg_pkg::LCE_ID_W-1:0]    out_lce_o,
  output logic [cce_cfg_pkg::LINE_ADDR_W-1:0] out_addr_o,
  output cce_msg_pkg::coh_state_e             out_state_o,
  output logic [cce_cfg_pkg::DATA_W-1:0]      out_data_o,
  output logic                                out_fill_o,
  input  logic                                out_done_i
);

  typedef enum logic [2:0] {
    st_idle,
    st_dir_read,
    st_calc,
    st_inv,
    st_mem_cmd,
    st_mem_wait,
    st_fill,
    st_dir_write
  } state_e;

  state_e state_q, state_d;
  logic   start_r;

  // Latched request and derived results
  cce_msg_pkg::lce_req_s          req_r;
  logic [NUM_LCE-1:0]             inv_mask_r;
  logic [NUM_LCE-1:0]             new_mask_r;
  logic                           new_excl_r;
  cce_msg_pkg::coh_state_e        grant_r;
  logic [cce_cfg_pkg::DATA_W-1:0] data_r;

  logic [cce_cfg_pkg::MAX_LCE-1:0] req_bit_wide;
  logic [NUM_LCE-1:0]              req_bit;
  logic [NUM_LCE-1:0]              other_mask;
  logic [NUM_LCE-1:0]              inv_mask_c;
  logic [NUM_LCE-1:0]              new_mask_c;
  logic                            new_excl_c;
  cce_msg_pkg::coh_state_e         grant_c;

  // Requester as a one-hot over the LCE mask
  assign req_bit_wide = {{(cce_cfg_pkg::MAX_LCE-1){1'b0}}, 1'b1} << req_r.lce;
  assign req_bit      = req_bit_wide[NUM_LCE-1:0];
  assign other_mask   = dir_r_mask_i & ~req_bit;

  // Coherence rule, applied to the entry read in st_dir_read
  always_comb begin
    if (req_r.write) begin
      inv_mask_c = other_mask;
      new_mask_c = req_bit;
      new_excl_c = 1'b1;
      grant_c    = cce_msg_pkg::e_coh_exclusive;
    end else begin
      // An exclusive holder elsewhere must give the line up
      inv_mask_c = dir_r_excl_i ? other_mask : '0;
      new_mask_c = (dir_r_mask_i & ~inv_mask_c) | req_bit;
      new_excl_c = 1'b0;
      grant_c    = cce_msg_pkg::e_coh_shared;
    end
  end

  always_comb begin
    state_d     = state_q;
    req_yumi_o  = 1'b0;
    resp_yumi_o = 1'b0;
    case (state_q)
      st_idle: begin
        if (req_v_i) begin
          req_yumi_o = 1'b1;
          state_d    = st_dir_read;
        end
      end
      st_dir_read: state_d = st_calc;
      st_calc:     state_d = st_inv;
      st_inv: begin
        if (out_done_i) begin
          state_d = st_mem_cmd;
        end
      end
      st_mem_cmd: begin
        if (mem_cmd_ready_i) begin
          state_d = st_mem_wait;
        end
      end
      st_mem_wait: begin
        if (resp_v_i) begin
          resp_yumi_o = 1'b1;
          state_d     = st_fill;
        end
      end
      st_fill: begin
        if (out_done_i) begin
          state_d = st_dir_write;
        end
      end
      st_dir_write: state_d = st_idle;
      default:      state_d = st_idle;
    endcase
  end

  // Start pulses in the first cycle of st_inv and st_fill
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
      start_r <= 1'b0;
    end else begin
      state_q <= state_d;
      start_r <= (state_q == st_calc) || resp_yumi_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      req_r <= req_i;
    end
    if (state_q == st_calc) begin
      inv_mask_r <= inv_mask_c;
      new_mask_r <= new_mask_c;
      new_excl_r <= new_excl_c;
      grant_r    <= grant_c;
    end
    if (resp_yumi_o) begin
      data_r <= resp_i.data;
    end
  end

  assign dir_r_v_o    = (state_q == st_dir_read);
  assign dir_r_addr_o = req_r.addr;
  assign dir_w_v_o    = (state_q == st_dir_write);
  assign dir_w_addr_o = req_r.addr;
  assign dir_w_mask_o = new_mask_r;
  assign dir_w_excl_o = new_excl_r;

  // Always a line read of the requested address
  assign mem_cmd_v_o    = (state_q == st_mem_cmd);
  assign mem_cmd_addr_o = req_r.addr;

  assign out_start_o    = start_r;
  assign out_inv_mask_o = inv_mask_r;
  assign out_lce_o      = req_r.lce;
  assign out_addr_o     = req_r.addr;
  assign out_state_o    = grant_r;
  assign out_data_o     = data_r;
  assign out_fill_o     = (state_q == st_fill);

endmodule

`default_nettype wire

// ==== logic/cce_directory.sv ====
/*
 * CCE directory
 * Sharer mask and exclusive bit for every line, with a registered
 * read port and a single write port
 */

`timescale 1ns/10ps
`default_nettype none

module cce_directory #(
  parameter int NUM_LCE = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // Read port, data one cycle after the strobe
  input  logic                                r_v_i,
  input  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] r_addr_i,
  output logic [NUM_LCE-1:0]                  r_mask_o,
  output logic                                r_excl_o,

  // Write port
  input  logic                                w_v_i,
  input  logic [cce_cfg_pkg::LINE_ADDR_W-1:0] w_addr_i,
  input  logic [NUM_LCE-1:0]                  w_mask_i,
  input  logic                                w_excl_i
);

  logic [NUM_LCE-1:0] mask_mem [cce_cfg_pkg::DIR_LINES];
  logic               excl_mem [cce_cfg_pkg::DIR_LINES];

  // Every line starts invalid with no sharers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < cce_cfg_pkg::DIR_LINES; i++) begin
        mask_mem[i] <= '0;
        excl_mem[i] <= 1'b0;
      end
    end else if (w_v_i) begin
      mask_mem[w_addr_i] <= w_mask_i;
      excl_mem[w_addr_i] <= w_excl_i;
    end
  end

  // Read result holds until the next strobe
  always_ff @(posedge clk_i) begin
    if (r_v_i) begin
      r_mask_o <= mask_mem[r_addr_i];
      r_excl_o <= excl_mem[r_addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/cce_msg_buffer.sv ====
/*
 * CCE inbound message buffer
 * One-entry register that takes valid/ready on the outer side and
 * offers valid/yumi to the controller
 */

`timescale 1ns/10ps
`default_nettype none

module cce_msg_buffer #(
  parameter type msg_t = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // Outer side
  input  logic v_i,
  input  msg_t data_i,
  output logic ready_o,

  // Inner side
  output logic v_o,
  output msg_t data_o,
  input  logic yumi_i
);

  logic full_r;
  msg_t data_r;

  // Accept only into an empty slot
  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (v_i && ready_o) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_r <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cce_msg_pkg.sv ====
/*
 * CCE message package
 * Coherence states, LCE command types and the inbound message
 * layouts seen by the engine
 */

`default_nettype none

package cce_msg_pkg;

  // State granted to an LCE with a fill
  typedef enum logic [1:0] {
    e_coh_invalid   = 2'd0,
    e_coh_shared    = 2'd1,
    e_coh_exclusive = 2'd2
  } coh_state_e;

  // Outbound LCE command kind
  typedef enum logic {
    e_cmd_inv  = 1'b0,
    e_cmd_fill = 1'b1
  } lce_cmd_type_e;

  // LCE request, 10 bits
  typedef struct packed {
    logic [cce_cfg_pkg::LCE_ID_W-1:0]    lce;
    logic [cce_cfg_pkg::LINE_ADDR_W-1:0] addr;
    logic                                write;
  } lce_req_s;

  // Memory response, 38 bits
  // Always a full line read, so only address and data
  typedef struct packed {
    logic [cce_cfg_pkg::LINE_ADDR_W-1:0] addr;
    logic [cce_cfg_pkg::DATA_W-1:0]      data;
  } mem_resp_s;

endpackage

`default_nettype wire

// ==== logic/cce_cfg_pkg.sv ====
/*
 * CCE configuration package
 * Width and size constants shared by the coherence engine
 */

`default_nettype none

package cce_cfg_pkg;

  // Line address, one directory entry per line
  localparam int LINE_ADDR_W = 6;

  // LCE identifier width and the most LCEs it can name
  localparam int LCE_ID_W = 3;
  localparam int MAX_LCE = 8;

  // Single data word per line
  localparam int DATA_W = 32;

  // Directory depth, covers the whole line address space
  localparam int DIR_LINES = 64;

endpackage

`default_nettype wire
